// File: sources.f
hw/or1420SocPkg.sv
hw/resetSequencer.sv
hw/swapByteCi.sv
hw/delayCi.sv
hw/busArbiter.sv
hw/or1420SocCore.sv
tb/or1420SocCore_chk.sv
tb/or1420SocCore_tb.sv

// File: tb/or1420SocCore_tb.sv
module or1420SocCore_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import or1420SocPkg::*;

  localparam int CYCLES_PER_US  = 3;
  localparam int TIMEOUT_CYCLES = 8;
  localparam int RELEASE_EDGES  = 16; // 2**(5-1) edges until the counter top bit sets.
  localparam int WAIT_LIMIT     = 100;

  logic                         s_systemClock;
  logic                         s_pllLocked;
  logic                         cpuReset;
  logic                         ciStart;
  ciIdT                         ciN;
  wordT                         ciDataA;
  wordT                         ciDataB;
  logic                         ciDone;
  wordT                         ciResult;
  logic [NR_OF_BUS_MASTERS-1:0] busRequests;
  logic                         beginTransaction;
  logic                         endTransaction;
  logic [NR_OF_BUS_MASTERS-1:0] busGrants;
  logic                         busIdle;
  logic                         busError;
  logic                         arbiterEndTransaction;
  integer                       seed;

  or1420SocCore #(
    .CYCLES_PER_MICROSECOND(CYCLES_PER_US),
    .BUS_TIMEOUT           (TIMEOUT_CYCLES)
  ) DUT (.*);

  initial begin
    s_systemClock = 1'b0;
    forever #5 s_systemClock = ~s_systemClock;
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      failRun("a checked value did not match.");
    end
  endtask

  // expected swap result built from the union views.
  function automatic wordT swapExpected(input wordT value, input logic halfSwap);
    swapWordT original;
    swapWordT swapped;
    original = value;
    if (halfSwap) begin
      swapped.halves = {original.halves[0], original.halves[1]};
    end else begin
      swapped.bytes = {original.bytes[0], original.bytes[1], original.bytes[2],
                       original.bytes[3]};
    end
    return swapped;
  endfunction

  task automatic expectQuietOutputs;
    checkValue("busGrants", busGrants, '0);
    checkValue("busError", busError, 0);
    checkValue("arbiterEndTransaction", arbiterEndTransaction, 0);
    checkValue("ciDone", ciDone, 0);
    checkValue("busIdle", busIdle, 1);
  endtask

  task automatic releaseReset;
    for (int edgeCount = 1; edgeCount <= RELEASE_EDGES; edgeCount++) begin
      @(posedge s_systemClock);
      @(negedge s_systemClock);
      checkValue("cpuReset", cpuReset, (edgeCount < RELEASE_EDGES) ? 1 : 0);
      expectQuietOutputs();
    end
  endtask

  task automatic swapRandomWords;
    wordT operand;
    wordT control;
    for (int i = 0; i < 8; i++) begin
      operand    = $random(seed);
      control    = $random(seed);
      control[0] = i[0]; // alternate byte reversal and halfword swap.
      @(posedge s_systemClock);
      ciStart <= 1'b1;
      ciN     <= SWAP_BYTE_CI_ID;
      ciDataA <= operand;
      ciDataB <= control;
      @(negedge s_systemClock);
      checkValue("ciDone", ciDone, 1);
      checkValue("ciResult", ciResult, swapExpected(operand, control[0]));
      @(posedge s_systemClock);
      ciStart <= 1'b0;
      @(negedge s_systemClock);
      checkValue("ciDone", ciDone, 0);
      checkValue("ciResult", ciResult, '0);
    end
  endtask

  task automatic runDelay(input wordT microSeconds);
    int expectedCycles;
    int cycles;
    expectedCycles = (microSeconds == '0) ? 1 : microSeconds * CYCLES_PER_US;
    cycles         = 0;
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= DELAY_CI_ID;
    ciDataA <= microSeconds;
    ciDataB <= '0;
    @(posedge s_systemClock);
    ciStart <= 1'b0; // start is sampled at this edge.
    @(negedge s_systemClock);
    while (ciDone !== 1'b1) begin
      if (cycles == WAIT_LIMIT) begin
        failRun("the delay instruction never signalled done.");
      end else begin
        @(posedge s_systemClock);
        cycles++;
        @(negedge s_systemClock);
      end
    end
    checkValue("delay cycles", cycles, expectedCycles);
    checkValue("ciResult", ciResult, '0);
    @(posedge s_systemClock);
    ciN     <= '0;
    ciDataA <= '0;
    @(negedge s_systemClock);
    checkValue("ciDone", ciDone, 0);
  endtask

  task automatic timeDelays;
    runDelay(32'd0);
    runDelay(32'd1);
    runDelay(32'd4);
  endtask

  task automatic issueUnownedInstruction;
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= 8'h2a; // no unit owns this number.
    ciDataA <= $random(seed);
    @(negedge s_systemClock);
    checkValue("ciDone", ciDone, 0);
    @(posedge s_systemClock);
    ciStart <= 1'b0;
    for (int cycle = 0; cycle < 20; cycle++) begin
      @(negedge s_systemClock);
      checkValue("ciDone", ciDone, 0);
      @(posedge s_systemClock);
    end
    ciN <= '0;
  endtask

  task automatic waitForGrant(input logic [3:0] expectedGrant, input int expectedCycles);
    int   cycles;
    logic grantSeen;
    cycles    = 0;
    grantSeen = 1'b0;
    while (!grantSeen) begin
      if (cycles == WAIT_LIMIT) begin
        failRun("no bus grant arrived in time.");
      end else begin
        @(posedge s_systemClock);
        cycles++;
        @(negedge s_systemClock);
        grantSeen = (busGrants != '0);
      end
    end
    checkValue("busGrants", busGrants, expectedGrant);
    checkValue("grant latency", cycles, expectedCycles);
  endtask

  // begin, then stay past the timeout to show an active bus never times out.
  task automatic holdTransaction(input logic [3:0] grant);
    @(posedge s_systemClock);
    beginTransaction <= 1'b1;
    @(posedge s_systemClock);
    beginTransaction <= 1'b0;
    repeat (TIMEOUT_CYCLES + 2) begin
      @(negedge s_systemClock);
      checkValue("busGrants", busGrants, grant);
      checkValue("busIdle", busIdle, 0);
      checkValue("busError", busError, 0);
      @(posedge s_systemClock);
    end
  endtask

  task automatic finishTransaction(input logic [3:0] nextRequests,
                                   input logic [3:0] nextGrant);
    @(posedge s_systemClock);
    endTransaction <= 1'b1;
    busRequests    <= nextRequests;
    @(posedge s_systemClock);
    endTransaction <= 1'b0;
    @(negedge s_systemClock);
    checkValue("busGrants", busGrants, '0);
    checkValue("busIdle", busIdle, 1);
    waitForGrant(nextGrant, 1); // one idle cycle before the next grant.
  endtask

  task automatic arbitratePriority;
    @(posedge s_systemClock);
    busRequests <= 4'b1101;
    waitForGrant(4'b1000, 1);
    holdTransaction(4'b1000);
    finishTransaction(4'b0101, 4'b0100);
    holdTransaction(4'b0100);
    finishTransaction(4'b0001, 4'b0001);
    @(posedge s_systemClock);
    busRequests <= '0; // camera gives up before beginning.
    @(posedge s_systemClock);
    @(negedge s_systemClock);
    checkValue("busGrants", busGrants, '0);
    checkValue("busIdle", busIdle, 1);
  endtask

  task automatic stallGrant;
    int cycles;
    @(posedge s_systemClock);
    busRequests <= 4'b0010;
    waitForGrant(4'b0010, 1);
    cycles = 0;
    while (busError !== 1'b1) begin
      if (cycles == WAIT_LIMIT) begin
        failRun("the arbiter never ended the stalled grant.");
      end else begin
        checkValue("busGrants", busGrants, 4'b0010);
        @(posedge s_systemClock);
        cycles++;
        if (cycles == TIMEOUT_CYCLES + 1) begin
          busRequests <= '0; // master leaves as the bus closes.
        end
        @(negedge s_systemClock);
      end
    end
    checkValue("timeout cycles", cycles, TIMEOUT_CYCLES + 1);
    checkValue("arbiterEndTransaction", arbiterEndTransaction, 1);
    checkValue("busGrants", busGrants, '0);
    @(posedge s_systemClock);
    @(negedge s_systemClock);
    expectQuietOutputs();
  endtask

  always @(negedge s_systemClock) begin
    if (DUT.coreChk.assertionFailures != 0) begin
      failRun("a bound assertion failed.");
    end
  end

  initial begin
    seed             = 32'h9d9a_cfa3;
    s_pllLocked      = 1'b0;
    ciStart          = 1'b0;
    ciN              = '0;
    ciDataA          = '0;
    ciDataB          = '0;
    busRequests      = '0;
    beginTransaction = 1'b0;
    endTransaction   = 1'b0;
    repeat (3) begin
      @(negedge s_systemClock);
      checkValue("cpuReset", cpuReset, 1);
      expectQuietOutputs();
    end
    @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    releaseReset();
    swapRandomWords();
    timeDelays();
    issueUnownedInstruction();
    arbitratePriority();
    stallGrant();
    repeat (2) @(posedge s_systemClock);
    if (DUT.coreChk.assertionFailures != 0) begin
      failRun("a bound assertion failed.");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: tb/or1420SocCore_chk.sv
module or1420SocCore_chk (
  input logic                                       s_systemClock,
  input logic                                       cpuReset,
  input logic                                       ciStart,
  input or1420SocPkg::ciIdT                         ciN,
  input logic                                       ciDone,
  input logic [or1420SocPkg::NR_OF_BUS_MASTERS-1:0] busGrants,
  input logic                                       busError
);
  timeunit 1ns;
  timeprecision 100ps;
  import or1420SocPkg::*;

  int   assertionFailures = 0;
  logic delayPending; // a delay start is waiting for its done.

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      delayPending <= 1'b0;
    end else if (ciStart && (ciN == DELAY_CI_ID)) begin
      delayPending <= 1'b1;
    end else if (ciDone) begin
      delayPending <= 1'b0;
    end
  end

  grantOneHot: assert property (@(posedge s_systemClock) $onehot0(busGrants)) else begin
    assertionFailures++;
    $error("busGrants 0x%0h is neither zero nor one-hot", busGrants);
  end

  errorSingleCycle: assert property (@(posedge s_systemClock) disable iff (cpuReset)
    busError |=> !busError) else begin
    assertionFailures++;
    $error("busError stayed high for more than one cycle");
  end

  // the swap answers in its start cycle, the delay later.
  doneHasStart: assert property (@(posedge s_systemClock) disable iff (cpuReset)
    ciDone |-> ((ciStart && (ciN == SWAP_BYTE_CI_ID)) || delayPending)) else begin
    assertionFailures++;
    $error("ciDone without a matching custom-instruction start");
  end

endmodule

bind or1420SocCore or1420SocCore_chk coreChk (.*);

// File: hw/or1420SocCore.sv
module or1420SocCore #(
  parameter int CYCLES_PER_MICROSECOND = 50,
  parameter int BUS_TIMEOUT            = 16,
  parameter int RESET_COUNT_BITS       = 5
) (
  input  logic                                       s_systemClock,
  input  logic                                       s_pllLocked,
  output logic                                       cpuReset,

  input  logic                                       ciStart,
  input  or1420SocPkg::ciIdT                         ciN,
  input  or1420SocPkg::wordT                         ciDataA,
  input  or1420SocPkg::wordT                         ciDataB,
  output logic                                       ciDone,
  output or1420SocPkg::wordT                         ciResult,

  input  logic [or1420SocPkg::NR_OF_BUS_MASTERS-1:0] busRequests,
  input  logic                                       beginTransaction,
  input  logic                                       endTransaction,
  output logic [or1420SocPkg::NR_OF_BUS_MASTERS-1:0] busGrants,
  output logic                                       busIdle,
  output logic                                       busError,
  output logic                                       arbiterEndTransaction
);
  import or1420SocPkg::*;

  logic s_swapByteDone;
  logic s_delayDone;
  wordT s_swapByteResult;
  wordT s_delayResult;

  resetSequencer #(
    .RESET_COUNT_BITS(RESET_COUNT_BITS)
  ) resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset)
  );

  swapByteCi #(
    .customInstructionId(SWAP_BYTE_CI_ID)
  ) swapByte (
    .ciStart (ciStart),
    .ciN     (ciN),
    .ciDataA (ciDataA),
    .ciDataB (ciDataB),
    .ciDone  (s_swapByteDone),
    .ciResult(s_swapByteResult)
  );

  delayCi #(
    .customInstructionId   (DELAY_CI_ID),
    .CYCLES_PER_MICROSECOND(CYCLES_PER_MICROSECOND)
  ) delayMicro (
    .s_systemClock(s_systemClock),
    .cpuReset     (cpuReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDone       (s_delayDone),
    .ciResult     (s_delayResult)
  );

  // units idle at zero, so a plain OR merges the answers.
  assign ciDone   = s_swapByteDone | s_delayDone;
  assign ciResult = s_swapByteResult | s_delayResult;

  busArbiter #(
    .NR_OF_MASTERS(NR_OF_BUS_MASTERS),
    .BUS_TIMEOUT  (BUS_TIMEOUT)
  ) arbiter (
    .s_systemClock        (s_systemClock),
    .cpuReset             (cpuReset),
    .busRequests          (busRequests),
    .beginTransaction     (beginTransaction),
    .endTransaction       (endTransaction),
    .busGrants            (busGrants),
    .busIdle              (busIdle),
    .busError             (busError),
    .arbiterEndTransaction(arbiterEndTransaction)
  );

endmodule

// File: hw/busArbiter.sv
module busArbiter #(
  parameter int NR_OF_MASTERS = 4,
  parameter int BUS_TIMEOUT   = 16
) (
  input  logic                     s_systemClock,
  input  logic                     cpuReset,
  input  logic [NR_OF_MASTERS-1:0] busRequests,
  input  logic                     beginTransaction,
  input  logic                     endTransaction,
  output logic [NR_OF_MASTERS-1:0] busGrants,
  output logic                     busIdle,
  output logic                     busError,
  output logic                     arbiterEndTransaction
);

  localparam logic [1:0] IDLE    = 2'd0;
  localparam logic [1:0] GRANTED = 2'd1;
  localparam logic [1:0] ACTIVE  = 2'd2;
  localparam logic [1:0] RELEASE = 2'd3;

  localparam int TIMEOUT_BITS = $clog2(BUS_TIMEOUT + 1);

  logic [1:0]               s_state;
  logic [NR_OF_MASTERS-1:0] s_winner;
  logic [TIMEOUT_BITS-1:0]  s_timeoutCount;
  logic                     s_requestDropped;

  // fixed priority, the highest request bit wins.
  always_comb begin
    s_winner = '0;
    for (int i = 0; i < NR_OF_MASTERS; i++) begin
      if (busRequests[i]) begin
        s_winner    = '0;
        s_winner[i] = 1'b1;
      end
    end
  end

  assign s_requestDropped = ((busRequests & busGrants) == '0);
  assign busIdle          = (s_state == IDLE) || (s_state == RELEASE);

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      s_state               <= IDLE;
      busGrants             <= '0;
      s_timeoutCount        <= '0;
      busError              <= 1'b0;
      arbiterEndTransaction <= 1'b0;
    end else begin
      busError              <= 1'b0;
      arbiterEndTransaction <= 1'b0;
      case (s_state)
        IDLE, RELEASE: begin
          busGrants      <= s_winner;
          s_timeoutCount <= TIMEOUT_BITS'(BUS_TIMEOUT);
          s_state        <= (|busRequests) ? GRANTED : IDLE;
        end
        GRANTED: begin
          if (endTransaction || (s_requestDropped && !beginTransaction)) begin
            busGrants <= '0; // master gave up or did a one-cycle transfer.
            s_state   <= RELEASE;
          end else if (beginTransaction) begin
            s_state <= ACTIVE;
          end else if (s_timeoutCount == '0) begin
            // master never started, so close the bus with an error.
            busGrants             <= '0;
            busError              <= 1'b1;
            arbiterEndTransaction <= 1'b1;
            s_state               <= RELEASE;
          end else begin
            s_timeoutCount <= s_timeoutCount - TIMEOUT_BITS'(1);
          end
        end
        ACTIVE: begin
          if (endTransaction) begin
            busGrants <= '0; // no timeout once begun.
            s_state   <= RELEASE;
          end
        end
        default: begin
          busGrants <= '0;
          s_state   <= IDLE;
        end
      endcase
    end
  end

endmodule

// File: hw/delayCi.sv
module delayCi #(
  parameter or1420SocPkg::ciIdT customInstructionId    = or1420SocPkg::DELAY_CI_ID,
  parameter int                 CYCLES_PER_MICROSECOND = 50
) (
  input  logic               s_systemClock,
  input  logic               cpuReset,
  input  logic               ciStart,
  input  or1420SocPkg::ciIdT ciN,
  input  or1420SocPkg::wordT ciDataA,
  output logic               ciDone,
  output or1420SocPkg::wordT ciResult
);
  import or1420SocPkg::*;

  localparam int PRESCALE_BITS =
    (CYCLES_PER_MICROSECOND > 1) ? $clog2(CYCLES_PER_MICROSECOND) : 1;
  localparam logic [PRESCALE_BITS-1:0] PRESCALE_RELOAD =
    PRESCALE_BITS'(CYCLES_PER_MICROSECOND - 1);

  wordT                     s_microSeconds;
  logic [PRESCALE_BITS-1:0] s_prescaler;
  logic                     s_busy;
  logic                     s_doneReg;
  logic                     s_startDelay;
  logic                     s_lastCycle;

  assign s_startDelay = ciStart && (ciN == customInstructionId) && !s_busy;

  // a count of zero ends like a count of one with an empty prescaler.
  assign s_lastCycle = (s_prescaler == '0) && (s_microSeconds <= wordT'(1));

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      s_busy         <= 1'b0;
      s_doneReg      <= 1'b0;
      s_microSeconds <= '0;
      s_prescaler    <= '0;
    end else begin
      s_doneReg <= 1'b0;
      if (s_startDelay) begin
        s_busy         <= 1'b1;
        s_microSeconds <= ciDataA;
        s_prescaler    <= (ciDataA == '0) ? '0 : PRESCALE_RELOAD; // zero gives one cycle.
      end else if (s_busy) begin
        if (s_lastCycle) begin
          s_busy    <= 1'b0;
          s_doneReg <= 1'b1; // single-cycle done pulse.
        end else if (s_prescaler == '0) begin
          s_microSeconds <= s_microSeconds - wordT'(1);
          s_prescaler    <= PRESCALE_RELOAD;
        end else begin
          s_prescaler <= s_prescaler - PRESCALE_BITS'(1);
        end
      end
    end
  end

  assign ciDone   = s_doneReg;
  assign ciResult = '0; // the delay returns no value.

endmodule

// File: hw/swapByteCi.sv
module swapByteCi #(
  parameter or1420SocPkg::ciIdT customInstructionId = or1420SocPkg::SWAP_BYTE_CI_ID
) (
  input  logic               ciStart,
  input  or1420SocPkg::ciIdT ciN,
  input  or1420SocPkg::wordT ciDataA,
  input  or1420SocPkg::wordT ciDataB,
  output logic               ciDone,
  output or1420SocPkg::wordT ciResult
);
  import or1420SocPkg::*;

  swapWordT s_operand;
  swapWordT s_swapped;
  logic     s_selected;

  assign s_operand  = ciDataA;
  assign s_selected = ciStart && (ciN == customInstructionId);

  always_comb begin
    s_swapped = s_operand;
    if (ciDataB[0]) begin
      s_swapped.halves[1] = s_operand.halves[0]; // halfword exchange.
      s_swapped.halves[0] = s_operand.halves[1];
    end else begin
      for (int i = 0; i < 4; i++) begin
        s_swapped.bytes[i] = s_operand.bytes[3-i]; // full byte reversal.
      end
    end
  end

  // answers in the start cycle itself.
  assign ciDone   = s_selected;
  assign ciResult = s_selected ? wordT'(s_swapped) : '0;

endmodule

// File: hw/resetSequencer.sv
module resetSequencer #(
  parameter int RESET_COUNT_BITS = 5
) (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset
);

  logic [RESET_COUNT_BITS-1:0] s_resetCount;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCount <= '0;
    end else if (!s_resetCount[RESET_COUNT_BITS-1]) begin
      s_resetCount <= s_resetCount + RESET_COUNT_BITS'(1); // saturates on the top bit.
    end
  end

  // processor leaves reset once the top bit is set.
  assign cpuReset = ~s_resetCount[RESET_COUNT_BITS-1];

endmodule

// File: hw/or1420SocPkg.sv
package or1420SocPkg;

  // data word as seen on the custom-instruction operand and result ports.
  typedef logic [31:0] wordT;

  // custom-instruction number carried on ciN.
  typedef logic [7:0] ciIdT;

  // the same 32 bits read as four bytes or as two halfwords.
  // bytes[3] and halves[1] hold the most significant part.
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } swapWordT;

  localparam ciIdT SWAP_BYTE_CI_ID = 8'd1;  // byte and halfword swap.
  localparam ciIdT DELAY_CI_ID     = 8'd6;  // blocking microsecond delay.

  // request order: data cache (bit 3), instruction cache, screen, camera (bit 0).
  localparam int NR_OF_BUS_MASTERS = 4;

endpackage
